// ==== Makefile ====
# Verilator simulation of the colour mixer testbench

TOP = colmix_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== include/colmix_config.svh ====
// Colour mixer build constants, included by the RTL and the testbench

`ifndef COLMIX_CONFIG_SVH
`define COLMIX_CONFIG_SVH

// number of 6-bit control registers behind the bus
`define COLMIX_NREGS 13

// priority of a transparent layer, it never beats an opaque one
`define COLMIX_PRI_OPAQUE 63

// register bus address width, addresses above the last register read 0
`define COLMIX_ADR_W 4

// compare chain runs on clocks 1 to 5 after pxl_cen
// so the next pulse may come on clock 6 at the earliest
`define COLMIX_MIN_CEN_GAP 6

`endif

// ==== src/colmix_blend_pipe.sv ====
// Sequenced priority compare chain with shadow and brightness output decisions

`timescale 1ns/100ps
`default_nettype none

`include "colmix_config.svh"

module colmix_blend_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  colmix_pkg::cand_t       cand0,
    input  colmix_pkg::cand_t       cand1,
    input  colmix_pkg::cand_t       cand2,
    input  colmix_pkg::cand_t       cand3,
    input  colmix_pkg::cand_t       cand4,
    input  logic                    sel,
    input  logic [1:0]              shd_in,
    input  colmix_pkg::colmix_cfg_t cfg,
    output colmix_pkg::pix_out_t    pix_out
);

    import colmix_pkg::*;

    // 0 idle after reset, 1..5 chain steps, 6 done
    logic [2:0] st;
    cand_t      win;
    logic       l1_win;
    logic [5:0] shd_p;
    logic       shd_sel;

    always_comb begin
        // mode 1 lets the sel pin pick layer 1 regardless of priority
        if (cfg.l1_mode) begin
            l1_win = sel;
        end else begin
            l1_win = cand1.pri < cand0.pri;
        end

        // code 0 gets the opaque value so no priority can pass it
        case (shd_in)
            2'd1:    shd_p = cfg.shd_thr[0];
            2'd2:    shd_p = cfg.shd_thr[1];
            2'd3:    shd_p = cfg.shd_thr[2];
            default: shd_p = 6'(`COLMIX_PRI_OPAQUE);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= 3'd0;
            win     <= '0;
            shd_sel <= 1'b0;
            pix_out <= '0;
        end else begin
            if (pxl_cen) begin
                // results of the previous pixel leave here
                pix_out.col   <= win.col;
                pix_out.col_n <= win.trn;
                pix_out.brit  <= win.pri >= cfg.brit_thr;
                pix_out.shd   <= shd_sel ? shd_in : 2'b00;
                st            <= 3'd1;
            end else if (st inside {[3'd1:3'd5]}) begin
                st <= st + 3'd1;
            end

            case (st)
                3'd1: begin
                    win.col <= l1_win ? cand1.col : cand0.col;
                    win.trn <= l1_win ? cand1.trn : cand0.trn;
                    // mode 1 always carries layer 1 priority forward
                    win.pri <= (l1_win | cfg.l1_mode) ? cand1.pri : cand0.pri;
                end
                3'd2: begin
                    if (cand2.pri < win.pri) begin
                        win <= cand2;
                    end
                end
                3'd3: begin
                    if (cand3.pri < win.pri) begin
                        win <= cand3;
                    end
                end
                3'd4: begin
                    if (cand4.pri < win.pri) begin
                        win <= cand4;
                    end
                end
                3'd5: begin
                    shd_sel <= shd_p < win.pri;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/colmix_layer_prio.sv ====
// Per-layer front end: transparency, priority choice and colour bank extension

`timescale 1ns/100ps
`default_nettype none

`include "colmix_config.svh"

module colmix_layer_prio #(
    parameter type pix_t = colmix_pkg::layer_wide_t
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  pix_t              pix,
    input  logic              full,
    input  logic              exten,
    input  logic [5:0]        fixed_pri,
    input  logic [2:0]        bank,
    output colmix_pkg::cand_t cand
);

    import colmix_pkg::*;

    cand_t nxt;
    logic  trn;

    always_comb begin
        // colour 0 of each palette is see-through
        trn = ~|pix.col[3:0];
        // full mode needs the whole byte at zero, bit 8 of wide layers is a bank bit
        if (full) begin
            trn = trn & ~|pix.col[7:4];
        end

        nxt.trn = trn;
        if (trn) begin
            nxt.pri = 6'(`COLMIX_PRI_OPAQUE);
        end else if (exten) begin
            nxt.pri = pix.pri;
        end else begin
            nxt.pri = fixed_pri;
        end

        // bank bits go above the code
        // wide layers have 9 colour bits, so only bank[1:0] survive here
        nxt.col = 11'({bank, pix.col});
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand <= '0;
        end else if (pxl_cen) begin
            cand <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== src/colmix_pkg.sv ====
// Shared struct types of the colour mixer, imported by RTL and testbench

`default_nettype none

package colmix_pkg;

    // layers 0 to 2
    typedef struct packed {
        logic [5:0] pri;
        logic [8:0] col;
    } layer_wide_t;

    // layers 3 and 4
    typedef struct packed {
        logic [5:0] pri;
        logic [7:0] col;
    } layer_narrow_t;

    // decoded control registers
    typedef struct packed {
        logic [4:0][5:0] fix_pri;
        logic [5:0]      brit_thr;
        // index 0 holds the threshold for shadow code 1
        logic [2:0][5:0] shd_thr;
        logic [1:0]      bank0;
        logic [1:0]      bank1;
        logic [1:0]      bank2;
        logic [2:0]      bank3;
        logic [2:0]      bank4;
        logic [4:0]      full;
        logic            l1_mode;
        logic [4:0]      exten;
    } colmix_cfg_t;

    // one layer after the front end
    typedef struct packed {
        logic [5:0]  pri;
        logic [10:0] col;
        logic        trn;
    } cand_t;

    typedef struct packed {
        logic [10:0] col;
        logic        col_n;
        logic        brit;
        logic [1:0]  shd;
    } pix_out_t;

endpackage

`default_nettype wire

// ==== src/colmix_regs.sv ====
// Wishbone classic slave holding the mixer control registers and their read-back

`timescale 1ns/100ps
`default_nettype none

`include "colmix_config.svh"

module colmix_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`COLMIX_ADR_W-1:0] adr,
    input  logic [7:0]               dat_w,
    output logic [7:0]               dat_r,
    output logic                     ack,
    output colmix_pkg::colmix_cfg_t  cfg
);

    logic [5:0] mmr [0:`COLMIX_NREGS-1];
    logic       acc;
    logic       adr_ok;

    // new access seen, answered on the next edge
    assign acc    = cyc & stb & ~ack;
    assign adr_ok = adr < `COLMIX_NREGS;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            dat_r <= 8'd0;
            for (int i = 0; i < `COLMIX_NREGS; i++) begin
                mmr[i] <= 6'd0;
            end
        end else begin
            ack <= acc;
            if (acc) begin
                // read data shows the value before a write on the same access
                dat_r <= adr_ok ? {2'b00, mmr[adr]} : 8'd0;
                if (we && adr_ok) begin
                    mmr[adr] <= dat_w[5:0];
                end
            end
        end
    end

    // register map unpacking
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            cfg.fix_pri[i] = mmr[i];
        end
        cfg.brit_thr   = mmr[5];
        cfg.shd_thr[0] = mmr[6];
        cfg.shd_thr[1] = mmr[7];
        cfg.shd_thr[2] = mmr[8];
        cfg.bank0      = mmr[9][1:0];
        cfg.bank1      = mmr[9][3:2];
        cfg.bank2      = mmr[9][5:4];
        cfg.bank3      = mmr[10][2:0];
        cfg.bank4      = mmr[10][5:3];
        cfg.full       = mmr[11][4:0];
        cfg.l1_mode    = mmr[11][5];
        cfg.exten      = mmr[12][4:0];
    end

endmodule

`default_nettype wire

// ==== src/colmix_top.sv ====
// Five-layer priority colour mixer top, register bus plus pixel path

`timescale 1ns/100ps
`default_nettype none

`include "colmix_config.svh"

module colmix_top (
    input  logic                      clk,
    input  logic                      rst,
    // register bus
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`COLMIX_ADR_W-1:0]  adr,
    input  logic [7:0]                dat_w,
    output logic [7:0]                dat_r,
    output logic                      ack,
    // pixel inputs
    input  logic                      pxl_cen,
    input  logic                      sel,
    input  colmix_pkg::layer_wide_t   lay0,
    input  colmix_pkg::layer_wide_t   lay1,
    input  colmix_pkg::layer_wide_t   lay2,
    input  colmix_pkg::layer_narrow_t lay3,
    input  colmix_pkg::layer_narrow_t lay4,
    input  logic [1:0]                shd_in,
    output colmix_pkg::pix_out_t      pix_out
);

    import colmix_pkg::*;

    colmix_cfg_t cfg;
    cand_t       cand [0:4];
    logic [1:0]  shd_l;

    // shadow code travels with the pixel sampled on the same pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shd_l <= 2'b00;
        end else if (pxl_cen) begin
            shd_l <= shd_in;
        end
    end

    colmix_regs u_regs (
        .clk(clk), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .cfg(cfg)
    );

    colmix_layer_prio #(.pix_t(layer_wide_t)) u_lay0 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pix(lay0),
        .full(cfg.full[0]), .exten(cfg.exten[0]), .fixed_pri(cfg.fix_pri[0]),
        .bank({1'b0, cfg.bank0}), .cand(cand[0])
    );

    colmix_layer_prio #(.pix_t(layer_wide_t)) u_lay1 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pix(lay1),
        .full(cfg.full[1]), .exten(cfg.exten[1]), .fixed_pri(cfg.fix_pri[1]),
        .bank({1'b0, cfg.bank1}), .cand(cand[1])
    );

    colmix_layer_prio #(.pix_t(layer_wide_t)) u_lay2 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pix(lay2),
        .full(cfg.full[2]), .exten(cfg.exten[2]), .fixed_pri(cfg.fix_pri[2]),
        .bank({1'b0, cfg.bank2}), .cand(cand[2])
    );

    colmix_layer_prio #(.pix_t(layer_narrow_t)) u_lay3 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pix(lay3),
        .full(cfg.full[3]), .exten(cfg.exten[3]), .fixed_pri(cfg.fix_pri[3]),
        .bank(cfg.bank3), .cand(cand[3])
    );

    colmix_layer_prio #(.pix_t(layer_narrow_t)) u_lay4 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pix(lay4),
        .full(cfg.full[4]), .exten(cfg.exten[4]), .fixed_pri(cfg.fix_pri[4]),
        .bank(cfg.bank4), .cand(cand[4])
    );

    colmix_blend_pipe u_blend (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .cand0(cand[0]), .cand1(cand[1]), .cand2(cand[2]),
        .cand3(cand[3]), .cand4(cand[4]),
        .sel(sel), .shd_in(shd_l), .cfg(cfg),
        .pix_out(pix_out)
    );

endmodule

`default_nettype wire

// ==== verif/colmix_chk.sv ====
// Bus handshake and output timing assertions, bound into the mixer top level

`timescale 1ns/100ps
`default_nettype none

module colmix_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 cyc,
    input logic                 stb,
    input logic                 ack,
    input logic                 pxl_cen,
    input colmix_pkg::pix_out_t pix_out
);

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack stayed high for more than one clock");

    ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(cyc && stb))
        else $error("ack rose without a bus request on the clock before");

    ack_low_in_reset: assert property (@(posedge clk) rst |-> !ack)
        else $error("ack high while reset is asserted");

    // outputs only move on the edge that samples pxl_cen
    out_on_cen: assert property (@(posedge clk) disable iff (rst)
        !$past(pxl_cen) |-> $stable(pix_out))
        else $error("pixel outputs changed outside a pxl_cen clock");

endmodule

bind colmix_top colmix_chk u_chk (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack),
    .pxl_cen(pxl_cen), .pix_out(pix_out)
);

`default_nettype wire

// ==== verif/colmix_tb.sv ====
// Testbench for the colour mixer covering bus access, random pixels against a model and reset

`timescale 1ns/100ps
`default_nettype none

`include "colmix_config.svh"

module colmix_tb;

    import colmix_pkg::*;

    localparam int CEN_PERIOD   = 8;
    localparam int N_TESTS      = 6;
    localparam int PIX_PER_TEST = 48;
    localparam int ACC_PER_TEST = 48;
    // allow four clocks per bus access and double the whole
    localparam int CYCLE_LIMIT  =
        2 * N_TESTS * (PIX_PER_TEST * CEN_PERIOD + ACC_PER_TEST * 4) + 200;

    logic          clk;
    logic          rst;
    logic          cyc;
    logic          stb;
    logic          we;
    logic [3:0]    adr;
    logic [7:0]    dat_w;
    logic [7:0]    dat_r;
    logic          ack;
    logic          pxl_cen;
    logic          sel;
    layer_wide_t   lay0;
    layer_wide_t   lay1;
    layer_wide_t   lay2;
    layer_narrow_t lay3;
    layer_narrow_t lay4;
    logic [1:0]    shd_in;
    pix_out_t      pix_out;

    // register contents as written over the bus
    logic [5:0] regs_m [0:`COLMIX_NREGS-1];
    logic       zero_nib;
    logic [5:0] pri_mask;
    int         cycles;
    int         test_errs;
    int         errors;
    int         checks;
    int         passed;
    int         failed;

    colmix_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // expected output for the pixel now on the inputs
    function automatic pix_out_t model_pixel();
        logic [8:0]  code [0:4];
        logic [5:0]  ext [0:4];
        logic [2:0]  bnk [0:4];
        logic [5:0]  pri [0:4];
        logic [10:0] col [0:4];
        logic        trn [0:4];
        int          w;
        logic [5:0]  thr;
        pix_out_t    r;
        code = '{lay0.col, lay1.col, lay2.col, {1'b0, lay3.col}, {1'b0, lay4.col}};
        ext  = '{lay0.pri, lay1.pri, lay2.pri, lay3.pri, lay4.pri};
        bnk  = '{{1'b0, regs_m[9][1:0]}, {1'b0, regs_m[9][3:2]}, {1'b0, regs_m[9][5:4]},
                 regs_m[10][2:0], regs_m[10][5:3]};
        for (int i = 0; i < 5; i++) begin
            // full flag widens the zero test to the whole byte
            trn[i] = code[i][3:0] == 4'h0 && (!regs_m[11][i] || code[i][7:4] == 4'h0);
            pri[i] = trn[i] ? 6'(`COLMIX_PRI_OPAQUE) : regs_m[12][i] ? ext[i] : regs_m[i];
            col[i] = (i < 3) ? {bnk[i][1:0], code[i]} : {bnk[i], code[i][7:0]};
        end
        // in layer 1 mode sel picks and layer 1 priority is carried either way
        if (regs_m[11][5]) begin
            w      = sel ? 1 : 0;
            pri[0] = pri[1];
        end else begin
            w = (pri[1] < pri[0]) ? 1 : 0;
        end
        for (int i = 2; i < 5; i++) begin
            if (pri[i] < pri[w]) begin
                w = i;
            end
        end
        thr     = (shd_in == 2'd0) ? 6'(`COLMIX_PRI_OPAQUE) : regs_m[5 + shd_in];
        r.col   = col[w];
        r.col_n = trn[w];
        r.brit  = pri[w] >= regs_m[5];
        r.shd   = (thr < pri[w]) ? shd_in : 2'd0;
        return r;
    endfunction

    task automatic drive_pixel();
        logic [8:0] code [0:4];
        logic [5:0] pri [0:4];
        for (int i = 0; i < 5; i++) begin
            code[i] = 9'($urandom);
            pri[i]  = 6'($urandom) & pri_mask;
            // mostly clear low nibbles and half of those with a clear upper nibble too
            if (zero_nib && $urandom_range(0, 3) != 0) begin
                code[i][3:0] = 4'h0;
                if ($urandom_range(0, 1) != 0) begin
                    code[i][7:4] = 4'h0;
                end
            end
        end
        lay0   = {pri[0], code[0]};
        lay1   = {pri[1], code[1]};
        lay2   = {pri[2], code[2]};
        lay3   = {pri[3], code[3][7:0]};
        lay4   = {pri[4], code[4][7:0]};
        sel    = 1'($urandom);
        shd_in = 2'($urandom);
    endtask

    // the first output of a burst belongs to the pixel before it
    task automatic run_pixels(input int n);
        pix_out_t exp_cur;
        pix_out_t exp_prev;
        logic     have_prev;
        have_prev = 1'b0;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            drive_pixel();
            exp_cur = model_pixel();
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            if (have_prev) begin
                checks++;
                assert (pix_out == exp_prev) else begin
                    $display("Fail at %0t: pixel %0d col,col_n,brit,shd got %h %b %b %0d, %s",
                             $time, k, pix_out.col, pix_out.col_n, pix_out.brit, pix_out.shd,
                             $sformatf("expected %h %b %b %0d", exp_prev.col,
                                       exp_prev.col_n, exp_prev.brit, exp_prev.shd));
                    test_errs++;
                end
            end
            exp_prev  = exp_cur;
            have_prev = 1'b1;
            repeat (CEN_PERIOD - 2) @(negedge clk);
        end
    endtask

    task automatic bus_access(input logic wr, input logic [3:0] a, input logic [7:0] d,
                              output logic [7:0] q);
        int waited;
        waited = 0;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = wr;
        adr    = a;
        dat_w  = d;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 8);
        assert (ack) else begin
            $display("register bus gave no ack for address %0d at %0t", a, $time);
            test_errs++;
        end
        q   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] a, input logic [5:0] d);
        logic [7:0] q;
        // random upper data bits that the slave drops
        bus_access(1'b1, a, {2'($urandom), d}, q);
        if (int'(a) < `COLMIX_NREGS) begin
            regs_m[a] = d;
        end
    endtask

    task automatic reg_read_check(input logic [3:0] a);
        logic [7:0] q;
        logic [7:0] exp;
        bus_access(1'b0, a, 8'h00, q);
        exp = 8'h00;
        if (int'(a) < `COLMIX_NREGS) begin
            exp = {2'b00, regs_m[a]};
        end
        checks++;
        assert (q == exp) else begin
            $display("Fail at %0t: register %0d read %h, expected %h", $time, a, q, exp);
            test_errs++;
        end
    endtask

    task automatic config_random(input logic [5:0] mask);
        for (int a = 0; a < `COLMIX_NREGS; a++) begin
            reg_write(4'(a), (a < 5) ? 6'($urandom) & mask : 6'($urandom));
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errs == 0) begin
            $display("test %0d %s: ok", num, name);
            passed++;
        end else begin
            $display("test %0d %s: %0d errors", num, name, test_errs);
            failed++;
        end
        errors    += test_errs;
        test_errs  = 0;
    endtask

    initial begin
        logic [4:0] full_v;
        void'($urandom(32'hc95c_a0dc));
        rst       = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = 4'd0;
        dat_w     = 8'd0;
        pxl_cen   = 1'b0;
        sel       = 1'b0;
        lay0      = '0;
        lay1      = '0;
        lay2      = '0;
        lay3      = '0;
        lay4      = '0;
        shd_in    = 2'd0;
        zero_nib  = 1'b0;
        pri_mask  = 6'h3f;
        test_errs = 0;
        errors    = 0;
        checks    = 0;
        passed    = 0;
        failed    = 0;
        regs_m    = '{default: 6'd0};
        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int a = 0; a < 16; a++) begin
            reg_write(4'(a), 6'($urandom));
        end
        for (int a = 0; a < 16; a++) begin
            reg_read_check(4'(a));
        end
        finish_test(1, "register access");

        // full flags all off then all on then random
        zero_nib = 1'b1;
        for (int r = 0; r < 3; r++) begin
            config_random(6'h3f);
            full_v = (r == 0) ? 5'h00 : (r == 1) ? 5'h1f : 5'($urandom);
            reg_write(4'd11, {1'($urandom), full_v});
            run_pixels(PIX_PER_TEST / 3);
        end
        zero_nib = 1'b0;
        finish_test(2, "opacity and colour");

        // narrow priority range makes ties frequent
        pri_mask = 6'h07;
        for (int r = 0; r < 3; r++) begin
            config_random(6'h07);
            run_pixels(PIX_PER_TEST / 3);
        end
        pri_mask = 6'h3f;
        finish_test(3, "priority selection");

        for (int r = 0; r < 3; r++) begin
            config_random(6'h3f);
            run_pixels(PIX_PER_TEST / 3);
        end
        finish_test(4, "brightness");

        for (int r = 0; r < 3; r++) begin
            config_random(6'h3f);
            for (int a = 6; a < 9; a++) begin
                reg_write(4'(a), 6'($urandom_range(0, 40)));
            end
            run_pixels(PIX_PER_TEST / 3);
        end
        finish_test(5, "shadow");

        // reset lands while the last pixel still waits in the pipe
        config_random(6'h3f);
        run_pixels(8);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        checks++;
        assert (pix_out == '0 && ack == 1'b0 && dat_r == 8'd0) else begin
            $display("Fail at %0t: outputs not cleared during reset", $time);
            test_errs++;
        end
        rst    = 1'b0;
        regs_m = '{default: 6'd0};
        for (int a = 0; a < 16; a++) begin
            reg_read_check(4'(a));
        end
        run_pixels(8);
        finish_test(6, "reset");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 N_TESTS, passed, failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
src/colmix_pkg.sv
src/colmix_regs.sv
src/colmix_layer_prio.sv
src/colmix_blend_pipe.sv
src/colmix_top.sv
verif/colmix_chk.sv
verif/colmix_tb.sv
